/* common/conv_pkg.sv */
package conv_pkg;

    // Data widths
    localparam int PIXEL_W          = 8;
    localparam int PROD_W           = 16;   // Full signed byte x byte product
    localparam int SUM_W            = 20;   // 16 products, 4 bits of growth

    // Geometry
    localparam int KERNEL_DIM       = 4;    // Rows per column, columns per window
    localparam int RESULTS_PER_WORD = 8;

    // One signed pixel or kernel tap
    typedef logic signed [PIXEL_W-1:0] pixel_t;

    // Input beat, byte r is row r
    typedef pixel_t [KERNEL_DIM-1:0] column_t;

    // Column 0 is the oldest; also used for the kernel
    typedef column_t [KERNEL_DIM-1:0] window_t;

    // Registered products, index is column * KERNEL_DIM + row
    typedef logic [KERNEL_DIM*KERNEL_DIM-1:0][PROD_W-1:0] product_t;

    // Lane k holds the k-th result, low byte first
    typedef pixel_t [RESULTS_PER_WORD-1:0] result_word_t;

endpackage

/* hdl/window_decoder.sv */
`timescale 1ns/10ps

module window_decoder (
    input  logic              clk,
    input  logic              rst_n,

    // Column stream in
    input  logic              i_in_valid,
    output logic              o_in_ready,
    input  conv_pkg::column_t i_in_data,
    input  logic              i_in_kernel,
    input  logic              i_in_last,

    // Window snapshot out
    output logic              o_win_valid,
    input  logic              i_win_ready,
    output conv_pkg::window_t o_win_data,
    output conv_pkg::window_t o_win_kernel,
    output logic              o_win_last
);

    localparam int FILL_W = $clog2(conv_pkg::KERNEL_DIM);
    localparam logic [FILL_W-1:0] FILL_FULL = FILL_W'(conv_pkg::KERNEL_DIM - 1);

    conv_pkg::window_t                          kernel;   // Working kernel
    conv_pkg::column_t [conv_pkg::KERNEL_DIM-2:0] hist;   // Previous columns, [0] oldest
    logic [FILL_W-1:0]                          fill;     // Columns held in hist
    conv_pkg::window_t                          window;
    logic                                       accept;
    logic                                       kernel_beat;
    logic                                       data_beat;
    logic                                       issue;

    // Stall only while a snapshot is held and not taken
    assign o_in_ready  = !o_win_valid || i_win_ready;
    assign accept      = i_in_valid && o_in_ready;
    assign kernel_beat = accept && i_in_kernel;
    assign data_beat   = accept && !i_in_kernel;

    // Fourth column of the strip onward completes a window
    assign issue = data_beat && (fill == FILL_FULL);

    // Newest column lands at the top index
    assign window = {i_in_data, hist};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel      <= '0;
            hist        <= '0;
            fill        <= '0;
            o_win_valid <= 1'b0;
        end else begin
            if (kernel_beat) begin
                kernel <= {i_in_data, kernel[conv_pkg::KERNEL_DIM-1:1]};
            end

            if (data_beat) begin
                if (i_in_last) begin
                    // End of strip, history starts over
                    hist <= '0;
                    fill <= '0;
                end else begin
                    hist <= {i_in_data, hist[conv_pkg::KERNEL_DIM-2:1]};
                    if (fill != FILL_FULL) begin
                        fill <= fill + 1'b1;
                    end
                end
            end

            if (o_in_ready) begin
                o_win_valid <= issue;
            end
        end
    end

    // Snapshot, so later kernel beats leave it untouched
    always_ff @(posedge clk) begin
        if (issue) begin
            o_win_data   <= window;
            o_win_kernel <= kernel;
            o_win_last   <= i_in_last;
        end
    end

endmodule

/* mac_array/mac_execute.sv */
`timescale 1ns/10ps

module mac_execute (
    input  logic              clk,
    input  logic              rst_n,

    // Window in
    input  logic              i_win_valid,
    output logic              o_win_ready,
    input  conv_pkg::window_t i_win_data,
    input  conv_pkg::window_t i_win_kernel,
    input  logic              i_win_last,

    // Saturated result out
    output logic              o_res_valid,
    input  logic              i_res_ready,
    output conv_pkg::pixel_t  o_res_data,
    output logic              o_res_last
);

    localparam int TAPS = conv_pkg::KERNEL_DIM * conv_pkg::KERNEL_DIM;
    localparam logic signed [conv_pkg::SUM_W-1:0] SAT_MAX = conv_pkg::SUM_W'(127);
    localparam logic signed [conv_pkg::SUM_W-1:0] SAT_MIN = -conv_pkg::SUM_W'(128);

    conv_pkg::product_t                 prod_next;
    conv_pkg::product_t                 p1_prod;
    logic                               p1_valid;
    logic                               p1_last;
    logic signed [conv_pkg::SUM_W-1:0]  sum;
    conv_pkg::pixel_t                   sat;
    logic                               s1_load;
    logic                               s2_load;

    // Each stage loads when empty or when its content moves on
    assign s2_load     = !o_res_valid || i_res_ready;
    assign s1_load     = !p1_valid || s2_load;
    assign o_win_ready = s1_load;

    // Elementwise multiply
    always_comb begin
        for (int c = 0; c < conv_pkg::KERNEL_DIM; c++) begin
            for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
                prod_next[c*conv_pkg::KERNEL_DIM + r] =
                    conv_pkg::PROD_W'(i_win_data[c][r]) *
                    conv_pkg::PROD_W'(i_win_kernel[c][r]);
            end
        end
    end

    // Adder tree and clamp on the registered products
    always_comb begin
        sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            sum = sum + conv_pkg::SUM_W'($signed(p1_prod[i]));
        end

        if (sum > SAT_MAX) begin
            sat = 8'sd127;
        end else if (sum < SAT_MIN) begin
            sat = -8'sd128;
        end else begin
            sat = sum[conv_pkg::PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1_valid    <= 1'b0;
            o_res_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                p1_valid <= i_win_valid;
            end
            if (s2_load) begin
                o_res_valid <= p1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_win_valid && s1_load) begin
            p1_prod <= prod_next;
            p1_last <= i_win_last;
        end
        if (p1_valid && s2_load) begin
            o_res_data <= sat;
            o_res_last <= p1_last;
        end
    end

endmodule

/* hdl/result_packer.sv */
`timescale 1ns/10ps

module result_packer (
    input  logic                   clk,
    input  logic                   rst_n,

    // Result bytes in
    input  logic                   i_res_valid,
    output logic                   o_res_ready,
    input  conv_pkg::pixel_t       i_res_data,
    input  logic                   i_res_last,

    // Packed words out
    output logic                   o_out_valid,
    input  logic                   i_out_ready,
    output conv_pkg::result_word_t o_out_data,
    output logic                   o_out_last
);

    localparam int LANE_W = $clog2(conv_pkg::RESULTS_PER_WORD);
    localparam logic [LANE_W-1:0] LANE_LAST = LANE_W'(conv_pkg::RESULTS_PER_WORD - 1);

    conv_pkg::result_word_t word_buf;   // Partial word, unfilled lanes zero
    conv_pkg::result_word_t word_next;
    logic [LANE_W-1:0]      lane;
    logic                   accept;
    logic                   word_done;

    // A held word that is not leaving blocks new results
    assign o_res_ready = !o_out_valid || i_out_ready;
    assign accept      = i_res_valid && o_res_ready;
    assign word_done   = (lane == LANE_LAST) || i_res_last;

    always_comb begin
        word_next       = word_buf;
        word_next[lane] = i_res_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_buf    <= '0;
            lane        <= '0;
            o_out_valid <= 1'b0;
        end else begin
            if (accept) begin
                if (word_done) begin
                    word_buf <= '0;   // Pads the next partial word
                    lane     <= '0;
                end else begin
                    word_buf <= word_next;
                    lane     <= lane + 1'b1;
                end
            end

            if (o_res_ready) begin
                o_out_valid <= accept && word_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && word_done) begin
            o_out_data <= word_next;
            o_out_last <= i_res_last;
        end
    end

endmodule

/* hdl/conv_engine.sv */
`timescale 1ns/10ps

module conv_engine (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   i_in_valid,
    output logic                   o_in_ready,
    input  conv_pkg::column_t      i_in_data,
    input  logic                   i_in_kernel,
    input  logic                   i_in_last,

    output logic                   o_out_valid,
    input  logic                   i_out_ready,
    output conv_pkg::result_word_t o_out_data,
    output logic                   o_out_last
);

    // Decode to execute
    logic              win_valid;
    logic              win_ready;
    conv_pkg::window_t win_data;
    conv_pkg::window_t win_kernel;
    logic              win_last;

    // Execute to packer
    logic              res_valid;
    logic              res_ready;
    conv_pkg::pixel_t  res_data;
    logic              res_last;

    window_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_in_valid   (i_in_valid),
        .o_in_ready   (o_in_ready),
        .i_in_data    (i_in_data),
        .i_in_kernel  (i_in_kernel),
        .i_in_last    (i_in_last),
        .o_win_valid  (win_valid),
        .i_win_ready  (win_ready),
        .o_win_data   (win_data),
        .o_win_kernel (win_kernel),
        .o_win_last   (win_last)
    );

    mac_execute u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_win_valid  (win_valid),
        .o_win_ready  (win_ready),
        .i_win_data   (win_data),
        .i_win_kernel (win_kernel),
        .i_win_last   (win_last),
        .o_res_valid  (res_valid),
        .i_res_ready  (res_ready),
        .o_res_data   (res_data),
        .o_res_last   (res_last)
    );

    result_packer u_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_res_valid  (res_valid),
        .o_res_ready  (res_ready),
        .i_res_data   (res_data),
        .i_res_last   (res_last),
        .o_out_valid  (o_out_valid),
        .i_out_ready  (i_out_ready),
        .o_out_data   (o_out_data),
        .o_out_last   (o_out_last)
    );

endmodule

/* testbench/tb_conv_engine.sv */
`timescale 1ns/10ps

module tb_conv_engine;

    localparam int RESET_CYCLES = 16;
    localparam int BEAT_BOUND   = 183;  // Worst case beats sent by all tests
    localparam int STALL_MARGIN = 8;    // Valid gaps and output stalls
    localparam int DRAIN_ALLOW  = 40;   // Per test, pipeline drain and idle check
    localparam int MAX_CYCLES   = BEAT_BOUND * STALL_MARGIN + RESET_CYCLES + 6 * DRAIN_ALLOW;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   i_in_valid;
    logic                   o_in_ready;
    conv_pkg::column_t      i_in_data;
    logic                   i_in_kernel;
    logic                   i_in_last;
    logic                   o_out_valid;
    logic                   i_out_ready = 1'b1;
    conv_pkg::result_word_t o_out_data;
    logic                   o_out_last;

    // Reference model state
    conv_pkg::window_t      model_kernel;
    conv_pkg::column_t      hist_q[$];          // [0] oldest
    conv_pkg::result_word_t pend_word;
    int                     pend_lane;
    conv_pkg::result_word_t exp_words[$];
    logic                   exp_last[$];

    conv_pkg::result_word_t got_word;
    logic                   got_last;
    string                  cur_test;
    bit                     bp_on = 1'b0;
    int                     word_errors;
    int                     flag_errors;
    int                     other_errors;
    int                     cycle_count;
    int                     seed_dummy;

    conv_engine i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_in_data   (i_in_data),
        .i_in_kernel (i_in_kernel),
        .i_in_last   (i_in_last),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_out_data  (o_out_data),
        .o_out_last  (o_out_last)
    );

    always #10 clk = ~clk;

    task automatic compare_word(input string name, input conv_pkg::result_word_t exp,
                                input conv_pkg::result_word_t act);
        if (exp !== act) begin
            word_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            flag_errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Dot product of window and kernel, clamped to a signed byte
    function automatic conv_pkg::pixel_t expected_result(input conv_pkg::window_t win,
                                                         input conv_pkg::window_t ker);
        int acc;
        acc = 0;
        for (int c = 0; c < conv_pkg::KERNEL_DIM; c++) begin
            for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
                acc += int'(win[c][r]) * int'(ker[c][r]);
            end
        end
        if (acc > 127) begin
            return 8'sd127;
        end else if (acc < -128) begin
            return -8'sd128;
        end
        return conv_pkg::pixel_t'(acc);
    endfunction

    function automatic conv_pkg::column_t random_column(input int span);
        conv_pkg::column_t col;
        for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
            col[r] = conv_pkg::pixel_t'(int'($urandom % span) - span / 2);
        end
        return col;
    endfunction

    task automatic model_beat(input conv_pkg::column_t col, input logic is_kernel,
                              input logic last);
        conv_pkg::window_t win;
        if (is_kernel) begin
            for (int c = 0; c < conv_pkg::KERNEL_DIM - 1; c++) begin
                model_kernel[c] = model_kernel[c+1];
            end
            model_kernel[conv_pkg::KERNEL_DIM-1] = col;
        end else begin
            hist_q.push_back(col);
            if (hist_q.size() == conv_pkg::KERNEL_DIM) begin
                for (int c = 0; c < conv_pkg::KERNEL_DIM; c++) begin
                    win[c] = hist_q[c];
                end
                pend_word[pend_lane] = expected_result(win, model_kernel);
                pend_lane++;
                hist_q.delete(0);
                if (pend_lane == conv_pkg::RESULTS_PER_WORD || last) begin
                    exp_words.push_back(pend_word);
                    exp_last.push_back(last);
                    pend_word = '0;
                    pend_lane = 0;
                end
            end
            if (last) begin
                hist_q.delete();
            end
        end
    endtask

    // Drives one beat, waits for the handshake, then updates the model
    task automatic send_beat(input conv_pkg::column_t col, input logic is_kernel,
                             input logic last, input bit gaps);
        int  gap;
        bit  accepted;
        gap      = gaps ? int'($urandom % 3) : 0;
        accepted = 1'b0;
        @(negedge clk);
        if (gap > 0) begin
            i_in_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        i_in_valid  = 1'b1;
        i_in_data   = col;
        i_in_kernel = is_kernel;
        i_in_last   = last;
        while (!accepted) begin
            @(posedge clk);
            accepted = o_in_ready;
        end
        model_beat(col, is_kernel, last);
    endtask

    task automatic load_kernel(input conv_pkg::window_t ker, input bit gaps);
        for (int c = 0; c < conv_pkg::KERNEL_DIM; c++) begin
            send_beat(ker[c], 1'b1, c == 1, gaps);   // Last flag must be ignored here
        end
    endtask

    task automatic finish_test();
        @(negedge clk);
        i_in_valid = 1'b0;
        i_in_last  = 1'b0;
        while (exp_words.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);   // Catch any extra word
    endtask

    task automatic reset_state();
        cur_test = "reset";
        compare_flag("reset in_ready", 1'b1, o_in_ready);
        compare_flag("reset out_valid", 1'b0, o_out_valid);
        repeat (10) @(posedge clk);
        compare_flag("reset idle out_valid", 1'b0, o_out_valid);
    endtask

    task automatic basic_convolution();
        conv_pkg::window_t ker;
        conv_pkg::column_t col;
        cur_test = "basic";
        for (int c = 0; c < conv_pkg::KERNEL_DIM; c++) begin
            for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
                ker[c][r] = conv_pkg::pixel_t'((c * 2 + r) % 3 - 1);
            end
        end
        load_kernel(ker, 1'b0);
        // 13 columns give 10 results, a full word then a padded one
        for (int i = 0; i < 13; i++) begin
            for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
                col[r] = conv_pkg::pixel_t'((i * 3 + r * 5) % 17 - 8);
            end
            send_beat(col, 1'b0, i == 12, 1'b0);
        end
        finish_test();
    endtask

    task automatic saturation();
        conv_pkg::window_t ker;
        conv_pkg::column_t col;
        cur_test = "saturation";
        ker = {16{8'sd127}};
        load_kernel(ker, 1'b0);
        for (int i = 0; i < 6; i++) begin
            col = (i < 4) ? {4{8'sd127}} : {4{-8'sd128}};
            send_beat(col, 1'b0, i == 5, 1'b0);
        end
        ker = {16{-8'sd128}};
        load_kernel(ker, 1'b0);
        for (int i = 0; i < 6; i++) begin
            for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
                col[r] = $urandom % 2 ? 8'sd127 : -8'sd128;
            end
            send_beat(col, 1'b0, i == 5, 1'b0);
        end
        finish_test();
    endtask

    task automatic strip_boundary();
        cur_test = "strips";
        load_kernel({random_column(8), random_column(8), random_column(8), random_column(8)},
                    1'b0);
        for (int i = 0; i < 6; i++) begin
            send_beat(random_column(16), 1'b0, i == 5, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            send_beat(random_column(16), 1'b0, i == 11, 1'b0);
        end
        finish_test();
    endtask

    task automatic kernel_reload();
        cur_test = "reload";
        load_kernel({random_column(8), random_column(8), random_column(8), random_column(8)},
                    1'b0);
        for (int i = 0; i < 5; i++) begin
            send_beat(random_column(16), 1'b0, 1'b0, 1'b0);
        end
        load_kernel({random_column(8), random_column(8), random_column(8), random_column(8)},
                    1'b0);
        for (int i = 0; i < 3; i++) begin
            send_beat(random_column(16), 1'b0, i == 2, 1'b0);
        end
        // Partial reload between strips
        send_beat(random_column(8), 1'b1, 1'b0, 1'b0);
        send_beat(random_column(8), 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            send_beat(random_column(16), 1'b0, i == 3, 1'b0);
        end
        finish_test();
    endtask

    task automatic back_pressure();
        int len;
        cur_test = "backpressure";
        bp_on    = 1'b1;
        for (int s = 0; s < 3; s++) begin
            len = 4 + int'($urandom % 12);
            load_kernel({random_column(16), random_column(16), random_column(16),
                         random_column(16)}, 1'b1);
            for (int i = 0; i < len; i++) begin
                if ($urandom % 8 == 0) begin
                    send_beat(random_column(16), 1'b1, 1'b0, 1'b1);
                end
                send_beat(random_column(256), 1'b0, i == len - 1, 1'b1);
            end
        end
        finish_test();
        bp_on = 1'b0;
    endtask

    always @(negedge clk) begin
        if (bp_on) begin
            i_out_ready = ($urandom % 2) == 0;
        end else begin
            i_out_ready = 1'b1;
        end
    end

    // Output word check on each transfer
    always @(posedge clk) begin
        if (rst_n && o_out_valid && i_out_ready) begin
            if (exp_words.size() == 0) begin
                other_errors++;
                $display("Test %s: output word %h arrived with none expected",
                         cur_test, o_out_data);
            end else begin
                got_word = exp_words.pop_front();
                got_last = exp_last.pop_front();
                compare_word(cur_test, got_word, o_out_data);
                compare_flag({cur_test, " last"}, got_last, o_out_last);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles with tests unfinished", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed_dummy   = $urandom(32'hab68);
        rst_n        = 1'b0;
        i_in_valid   = 1'b0;
        i_in_data    = '0;
        i_in_kernel  = 1'b0;
        i_in_last    = 1'b0;
        model_kernel = '0;
        pend_word    = '0;
        pend_lane    = 0;
        word_errors  = 0;
        flag_errors  = 0;
        other_errors = 0;
        cycle_count  = 0;
        cur_test     = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        basic_convolution();
        saturation();
        strip_boundary();
        kernel_reload();
        back_pressure();

        $display("Error counts: word %0d, flag %0d, other %0d",
                 word_errors, flag_errors, other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* src.f */
common/conv_pkg.sv
hdl/window_decoder.sv
mac_array/mac_execute.sv
hdl/result_packer.sv
hdl/conv_engine.sv
testbench/tb_conv_engine.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_conv_engine -f src.f
	out=$$(./obj_dir/Vtb_conv_engine); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
